// File: rtl/fetch_pkg.sv
package fetch_pkg;

	localparam logic [31:0] entry_addr = 32'h0000_0100;

	localparam int line_words = 8;
	localparam int line_bytes = line_words * 4;
	localparam int cache_lines = 16;

	localparam int offset_bits = $clog2(line_words);
	localparam int index_bits = $clog2(cache_lines);
	localparam int tag_bits = 32 - index_bits - offset_bits - 2;

	// Fetch unit states.
	typedef enum logic [2:0] {
		ifu_idle,       // Waiting for run.
		ifu_lookup,     // Probe cycle, then compare cycle.
		ifu_refill_req, // Raise the line request.
		ifu_refill,     // Beats streaming in.
		ifu_hold,       // Instruction waits for decode.
		ifu_release     // Wait for ack to drop.
	} ifu_state_t;

endpackage

// File: rtl/bus_pkg.sv
package bus_pkg;

	typedef enum logic [1:0] {
		bus_read_word  = 2'd0,
		bus_write_word = 2'd1,
		bus_read_line  = 2'd2
	} bus_op_t;

	localparam int burst_len = 8;
	localparam int burst_bits = $clog2(burst_len);

	localparam int mem_words = 4096;
	localparam int mem_addr_bits = $clog2(mem_words);

	typedef enum logic {
		m_host,
		m_ifu
	} master_t;

	typedef enum logic [1:0] {
		arb_idle,
		arb_busy,
		arb_done
	} arb_state_t;

endpackage

// File: rtl/icache.sv
`timescale 1ns/1ns

module icache (
	input  logic        clock,
	input  logic        reset,

	input  logic [31:0] lookup_addr,
	output logic        hit,
	output logic [31:0] cache_rdata,

	input  logic        fill_valid,
	input  logic [31:0] fill_addr,
	input  logic [31:0] fill_data,
	input  logic        fill_last
);

	import fetch_pkg::*;

	logic [tag_bits-1:0] tags [cache_lines];
	logic [31:0] data [cache_lines * line_words];
	logic [cache_lines-1:0] valid;

	logic [offset_bits-1:0] lk_off;
	logic [index_bits-1:0] lk_idx;
	logic [tag_bits-1:0] lk_tag;
	logic [offset_bits-1:0] fl_off;
	logic [index_bits-1:0] fl_idx;
	logic [tag_bits-1:0] fl_tag;

	assign lk_off = lookup_addr[2 +: offset_bits];
	assign lk_idx = lookup_addr[2 + offset_bits +: index_bits];
	assign lk_tag = lookup_addr[31 -: tag_bits];

	assign fl_off = fill_addr[2 +: offset_bits];
	assign fl_idx = fill_addr[2 + offset_bits +: index_bits];
	assign fl_tag = fill_addr[31 -: tag_bits];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
			hit <= 1'b0;
		end else begin
			if (fill_valid && fill_last)
				valid[fl_idx] <= 1'b1; // Line complete.
			hit <= valid[lk_idx] && (tags[lk_idx] == lk_tag);
		end
	end

	always_ff @(posedge clock) begin
		if (fill_valid)
			data[{fl_idx, fl_off}] <= fill_data;
		if (fill_valid && fill_last)
			tags[fl_idx] <= fl_tag;
		cache_rdata <= data[{lk_idx, lk_off}];
	end

endmodule

// File: rtl/main_memory.sv
`timescale 1ns/1ns

module main_memory (
	input  logic              clock,

	input  logic              mem_req,
	input  bus_pkg::bus_op_t  mem_op,
	input  logic [31:0]       mem_addr,
	input  logic [31:0]       mem_wdata,
	output logic              mem_beat,
	output logic [31:0]       mem_rdata,
	output logic              mem_last
);

	import bus_pkg::*;

	logic [31:0] mem [mem_words];

	logic [mem_addr_bits-1:0] word;
	logic [mem_addr_bits-1:0] line_base;
	logic [mem_addr_bits-1:0] ptr;
	logic [burst_bits-1:0] remain = '0; // Beats still owed.

	assign word = mem_addr[2 +: mem_addr_bits];
	assign line_base = {word[mem_addr_bits-1:burst_bits], {burst_bits{1'b0}}};

	always_ff @(posedge clock) begin
		mem_beat <= 1'b0;
		mem_last <= 1'b0;
		if (mem_req) begin
			case (mem_op)
				bus_write_word: begin
					mem[word] <= mem_wdata;
				end
				bus_read_word: begin
					mem_beat <= 1'b1;
					mem_last <= 1'b1;
					mem_rdata <= mem[word];
				end
				bus_read_line: begin
					mem_beat <= 1'b1;
					mem_rdata <= mem[line_base];
					ptr <= line_base + 1'b1;
					remain <= burst_bits'(burst_len - 1);
				end
				default: ;
			endcase
		end else if (remain != '0) begin
			mem_beat <= 1'b1;
			mem_last <= (remain == burst_bits'(1));
			mem_rdata <= mem[ptr];
			ptr <= ptr + 1'b1;
			remain <= remain - 1'b1;
		end
	end

endmodule

// File: rtl/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter (
	input  logic              clock,
	input  logic              reset,

	input  logic              host_req,
	input  bus_pkg::bus_op_t  host_op,
	input  logic [31:0]       host_addr,
	input  logic [31:0]       host_wdata,
	output logic              host_beat,
	output logic [31:0]       host_rdata,
	output logic              host_ack,

	input  logic              ifu_req,
	input  bus_pkg::bus_op_t  ifu_op,
	input  logic [31:0]       ifu_addr,
	input  logic [31:0]       ifu_wdata,
	output logic              ifu_beat,
	output logic [31:0]       ifu_rdata,
	output logic              ifu_ack,

	output logic              mem_req,
	output bus_pkg::bus_op_t  mem_op,
	output logic [31:0]       mem_addr,
	output logic [31:0]       mem_wdata,
	input  logic              mem_beat,
	input  logic [31:0]       mem_rdata,
	input  logic              mem_last
);

	import bus_pkg::*;

	arb_state_t state;
	master_t owner;

	logic busy_beat;
	logic owner_req;

	assign busy_beat = (state == arb_busy) && mem_beat;
	assign host_beat = busy_beat && (owner == m_host);
	assign ifu_beat = busy_beat && (owner == m_ifu);
	assign host_rdata = mem_rdata;
	assign ifu_rdata = mem_rdata;

	assign owner_req = (owner == m_host) ? host_req : ifu_req;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= arb_idle;
			owner <= m_host;
			mem_req <= 1'b0;
			host_ack <= 1'b0;
			ifu_ack <= 1'b0;
		end else begin
			case (state)
				arb_idle: begin
					if (host_req) begin // Host wins a tie.
						owner <= m_host;
						mem_op <= host_op;
						mem_addr <= host_addr;
						mem_wdata <= host_wdata;
						mem_req <= 1'b1;
						state <= arb_busy;
					end else if (ifu_req) begin
						owner <= m_ifu;
						mem_op <= ifu_op;
						mem_addr <= ifu_addr;
						mem_wdata <= ifu_wdata;
						mem_req <= 1'b1;
						state <= arb_busy;
					end
				end

				arb_busy: begin
					mem_req <= 1'b0;
					// Writes finish once memory has taken them.
					if (mem_op == bus_write_word || (mem_beat && mem_last)) begin
						if (owner == m_host)
							host_ack <= 1'b1;
						else
							ifu_ack <= 1'b1;
						state <= arb_done;
					end
				end

				arb_done: begin
					if (!owner_req) begin
						host_ack <= 1'b0;
						ifu_ack <= 1'b0;
						state <= arb_idle;
					end
				end

				default: state <= arb_idle;
			endcase
		end
	end

	a_one_ack: assert property (@(posedge clock) disable iff (reset)
		!(host_ack && ifu_ack));

endmodule

// File: rtl/ifu.sv
`timescale 1ns/1ns

module ifu (
	input  logic              clock,
	input  logic              reset,
	input  logic              run,

	output logic              ifu_req,
	output bus_pkg::bus_op_t  ifu_op,
	output logic [31:0]       ifu_addr,
	input  logic              ifu_beat,
	input  logic [31:0]       ifu_rdata,
	input  logic              ifu_ack,

	output logic [31:0]       lookup_addr,
	input  logic              hit,
	input  logic [31:0]       cache_rdata,

	output logic              fill_valid,
	output logic [31:0]       fill_addr,
	output logic [31:0]       fill_data,
	output logic              fill_last,

	input  logic              jump_wrong,
	input  logic [31:0]       jump_addr,

	output logic              idu_valid,
	output logic [31:0]       inst,
	output logic [31:0]       inst_pc,
	input  logic              idu_ready
);

	import fetch_pkg::*;
	import bus_pkg::*;

	ifu_state_t state;

	logic [31:0] pc;
	logic [31:0] pc_seq;
	logic probed;
	logic [offset_bits-1:0] beat_cnt;
	logic fwd_done;
	logic redir_pend;
	logic [31:0] redir_addr;
	logic take;
	logic beat_match;
	logic in_refill;

	assign ifu_op = bus_read_line;
	assign lookup_addr = pc;
	assign pc_seq = pc + 32'd4;

	// A redirect in the same cycle overrides the transfer.
	assign take = idu_valid && idu_ready && !jump_wrong;

	assign in_refill = (state == ifu_refill_req) || (state == ifu_refill);

	assign fill_valid = (state == ifu_refill) && ifu_beat;
	assign fill_addr = {ifu_addr[31:offset_bits+2], beat_cnt, 2'b00};
	assign fill_data = ifu_rdata;
	assign fill_last = fill_valid && (&beat_cnt); // Final word of the line.

	// Critical word goes straight to decode.
	assign beat_match = fill_valid && !fwd_done && !redir_pend && !jump_wrong
		&& (beat_cnt == pc[2 +: offset_bits]);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ifu_idle;
			pc <= entry_addr;
			probed <= 1'b0;
			ifu_req <= 1'b0;
			beat_cnt <= '0;
			fwd_done <= 1'b0;
			redir_pend <= 1'b0;
			idu_valid <= 1'b0;
		end else begin
			// Line in flight, so a redirect only gets recorded.
			if (in_refill) begin
				if (jump_wrong) begin
					redir_pend <= 1'b1;
					redir_addr <= jump_addr;
					idu_valid <= 1'b0;
				end else if (take) begin
					idu_valid <= 1'b0;
					pc <= pc_seq;
				end
			end

			case (state)
				ifu_idle: begin
					if (jump_wrong)
						pc <= jump_addr;
					if (run)
						state <= ifu_lookup;
				end

				ifu_lookup: begin
					if (jump_wrong) begin
						pc <= jump_addr;
						probed <= 1'b0; // Probe again.
					end else if (!probed) begin
						probed <= 1'b1;
					end else begin
						probed <= 1'b0;
						if (hit) begin
							idu_valid <= 1'b1;
							inst <= cache_rdata;
							inst_pc <= pc;
							state <= ifu_hold;
						end else begin
							state <= ifu_refill_req;
						end
					end
				end

				ifu_refill_req: begin
					if (!ifu_ack) begin
						ifu_req <= 1'b1;
						ifu_addr <= {pc[31:offset_bits+2], {(offset_bits+2){1'b0}}};
						beat_cnt <= '0;
						fwd_done <= 1'b0;
						state <= ifu_refill;
					end
				end

				ifu_refill: begin
					if (ifu_beat)
						beat_cnt <= beat_cnt + 1'b1;
					if (beat_match) begin
						idu_valid <= 1'b1;
						inst <= ifu_rdata;
						inst_pc <= pc;
						fwd_done <= 1'b1;
					end
					if (ifu_ack) begin
						ifu_req <= 1'b0;
						state <= ifu_release;
					end
				end

				ifu_hold: begin
					if (jump_wrong) begin
						idu_valid <= 1'b0;
						pc <= jump_addr;
						state <= ifu_lookup;
					end else if (idu_ready) begin
						idu_valid <= 1'b0;
						pc <= pc_seq;
						state <= ifu_lookup;
					end
				end

				ifu_release: begin
					if (jump_wrong) begin
						idu_valid <= 1'b0;
						redir_pend <= 1'b0;
						pc <= jump_addr;
						if (!ifu_ack)
							state <= ifu_lookup;
						else
							redir_pend <= 1'b1; // Still waiting, keep the target.
						redir_addr <= jump_addr;
					end else if (take) begin
						idu_valid <= 1'b0;
						pc <= pc_seq;
						if (!ifu_ack)
							state <= ifu_lookup;
					end else if (!ifu_ack) begin
						if (redir_pend) begin
							pc <= redir_addr;
							redir_pend <= 1'b0;
							state <= ifu_lookup;
						end else if (idu_valid) begin
							state <= ifu_hold;
						end else begin
							state <= ifu_lookup;
						end
					end
				end

				default: state <= ifu_idle;
			endcase
		end
	end

	// Decode sees a stable instruction until it takes it or a redirect drops it.
	a_idu_hold: assert property (@(posedge clock) disable iff (reset)
		idu_valid && !idu_ready && !jump_wrong
		|=> idu_valid && $stable(inst) && $stable(inst_pc));

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
	input  logic              clock,
	input  logic              reset,
	input  logic              run,

	input  logic              host_req,
	input  bus_pkg::bus_op_t  host_op,
	input  logic [31:0]       host_addr,
	input  logic [31:0]       host_wdata,
	output logic              host_beat,
	output logic [31:0]       host_rdata,
	output logic              host_ack,

	input  logic              jump_wrong,
	input  logic [31:0]       jump_addr,

	output logic              idu_valid,
	output logic [31:0]       inst,
	output logic [31:0]       inst_pc,
	input  logic              idu_ready
);

	import bus_pkg::*;

	logic ifu_req;
	bus_op_t ifu_op;
	logic [31:0] ifu_addr;
	logic ifu_beat;
	logic [31:0] ifu_rdata;
	logic ifu_ack;

	logic [31:0] lookup_addr;
	logic hit;
	logic [31:0] cache_rdata;
	logic fill_valid;
	logic [31:0] fill_addr;
	logic [31:0] fill_data;
	logic fill_last;

	logic mem_req;
	bus_op_t mem_op;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic mem_beat;
	logic [31:0] mem_rdata;
	logic mem_last;

	ifu ifu_inst (
		.clock(clock), .reset(reset), .run(run),
		.ifu_req(ifu_req), .ifu_op(ifu_op), .ifu_addr(ifu_addr),
		.ifu_beat(ifu_beat), .ifu_rdata(ifu_rdata), .ifu_ack(ifu_ack),
		.lookup_addr(lookup_addr), .hit(hit), .cache_rdata(cache_rdata),
		.fill_valid(fill_valid), .fill_addr(fill_addr),
		.fill_data(fill_data), .fill_last(fill_last),
		.jump_wrong(jump_wrong), .jump_addr(jump_addr),
		.idu_valid(idu_valid), .inst(inst), .inst_pc(inst_pc), .idu_ready(idu_ready)
	);

	icache icache_inst (
		.clock(clock), .reset(reset),
		.lookup_addr(lookup_addr), .hit(hit), .cache_rdata(cache_rdata),
		.fill_valid(fill_valid), .fill_addr(fill_addr),
		.fill_data(fill_data), .fill_last(fill_last)
	);

	bus_arbiter bus_arbiter_inst (
		.clock(clock), .reset(reset),
		.host_req(host_req), .host_op(host_op), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_beat(host_beat),
		.host_rdata(host_rdata), .host_ack(host_ack),
		.ifu_req(ifu_req), .ifu_op(ifu_op), .ifu_addr(ifu_addr),
		.ifu_wdata(32'd0), .ifu_beat(ifu_beat), // Fetch never writes.
		.ifu_rdata(ifu_rdata), .ifu_ack(ifu_ack),
		.mem_req(mem_req), .mem_op(mem_op), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_beat(mem_beat), .mem_rdata(mem_rdata), .mem_last(mem_last)
	);

	main_memory main_memory_inst (
		.clock(clock),
		.mem_req(mem_req), .mem_op(mem_op), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_beat(mem_beat), .mem_rdata(mem_rdata), .mem_last(mem_last)
	);

endmodule

// File: testbench/fetch_checker.sv
`timescale 1ns/1ns

module fetch_checker (
	input logic              clock,
	input logic              reset,
	input logic              run,
	input logic              host_req,
	input bus_pkg::bus_op_t  host_op,
	input logic [31:0]       host_addr,
	input logic [31:0]       host_wdata,
	input logic              host_beat,
	input logic [31:0]       host_rdata,
	input logic              host_ack,
	input logic              jump_wrong,
	input logic [31:0]       jump_addr,
	input logic              idu_valid,
	input logic [31:0]       inst,
	input logic [31:0]       inst_pc,
	input logic              idu_ready
);

	import fetch_pkg::*;
	import bus_pkg::*;

	logic [31:0] ref_mem [mem_words];
	logic ref_written [mem_words];
	logic [mem_addr_bits-1:0] widx;
	logic [31:0] exp_pc = entry_addr;
	logic ack_q = 1'b0;
	logic beat_seen = 1'b0;
	int checks = 0;
	int errors = 0;
	int mark_checks = 0;
	int mark_errors = 0;

	assign widx = host_addr[2 +: mem_addr_bits];

	// Program image word, a fixed hash of the byte address.
	function automatic logic [31:0] image_word(input logic [31:0] addr);
		logic [31:0] x;
		x = addr * 32'h9e37_79b1;
		return x ^ (x >> 15) ^ {addr[15:0], addr[31:16]};
	endfunction

	task automatic note_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d checks, %0d errors", name, checks - mark_checks, errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	initial begin
		for (int i = 0; i < mem_words; i++)
			ref_written[i] = 1'b0;
	end

	always @(negedge clock) begin
		if (reset) begin
			exp_pc = entry_addr;
			ack_q = 1'b0;
			beat_seen = 1'b0;
		end else begin
			if (!run && idu_valid)
				note_failure("idu_valid rose while run was low");
			if (host_req && host_beat) begin
				checks++;
				beat_seen = 1'b1;
				if (!ref_written[widx])
					note_failure($sformatf("host read of %h, which was never written", host_addr));
				else if (host_rdata !== ref_mem[widx]) begin
					errors++;
					$display("ERR host_rdata at %h: got %h expected %h",
						host_addr, host_rdata, ref_mem[widx]);
				end
			end
			if (host_ack && !ack_q) begin
				if (host_op == bus_write_word) begin
					ref_mem[widx] = host_wdata; // Memory took the word.
					ref_written[widx] = 1'b1;
				end else if (!beat_seen) begin
					note_failure("host read ended without a data beat");
				end
				beat_seen = 1'b0;
			end
			ack_q = host_ack;

			if (jump_wrong) begin
				exp_pc = jump_addr; // Same-cycle transfer does not count.
			end else if (idu_valid && idu_ready) begin
				checks++;
				if (inst_pc !== exp_pc) begin
					errors++;
					$display("ERR inst_pc: got %h expected %h", inst_pc, exp_pc);
				end else if (inst !== image_word(exp_pc)) begin
					errors++;
					$display("ERR inst at %h: got %h expected %h", exp_pc, inst, image_word(exp_pc));
				end
				exp_pc = exp_pc + 32'd4;
			end
		end
	end

endmodule

// File: testbench/tb_fetch.sv
`timescale 1ns/1ns

module tb_fetch;

	import fetch_pkg::*;
	import bus_pkg::*;

	localparam int timeout_cycles = 200;

	logic clock = 1'b0;
	logic reset;
	logic run;
	logic host_req;
	bus_op_t host_op;
	logic [31:0] host_addr;
	logic [31:0] host_wdata;
	logic host_beat;
	logic [31:0] host_rdata;
	logic host_ack;
	logic jump_wrong;
	logic [31:0] jump_addr;
	logic idu_valid;
	logic [31:0] inst;
	logic [31:0] inst_pc;
	logic idu_ready;

	integer seed = 32'he6ea;
	int span;

	always #50 clock = ~clock;

	fetch_top fetch_top_inst (.*);
	fetch_checker fetch_checker_inst (.*);

	function automatic logic ready_draw(input int low_pct);
		return ({$random(seed)} % 100) >= low_pct;
	endfunction

	task automatic host_access(input bus_op_t op, input logic [31:0] addr,
			input logic [31:0] wdata);
		int n;
		host_req <= 1'b1;
		host_op <= op;
		host_addr <= addr;
		host_wdata <= wdata;
		n = 0;
		while (!host_ack && n < timeout_cycles) begin
			@(posedge clock);
			n++;
		end
		if (!host_ack)
			fetch_checker_inst.note_failure("timed out waiting for host_ack to rise");
		host_req <= 1'b0;
		n = 0;
		while (host_ack && n < timeout_cycles) begin
			@(posedge clock);
			n++;
		end
		if (host_ack)
			fetch_checker_inst.note_failure("timed out waiting for host_ack to fall");
	endtask

	// Span is the cycle distance from the first to the last accepted word.
	task automatic accept_instructions(input int n, input int low_pct, output int span);
		int got;
		int idle;
		int cyc;
		int first;
		got = 0;
		idle = 0;
		cyc = 0;
		first = 0;
		span = 0;
		idu_ready <= ready_draw(low_pct);
		while (got < n && idle < timeout_cycles) begin
			@(posedge clock);
			cyc++;
			idle++;
			if (idu_valid && idu_ready && !jump_wrong) begin
				if (got == 0)
					first = cyc;
				got++;
				idle = 0;
				span = cyc - first;
			end
			idu_ready <= (got < n) ? ready_draw(low_pct) : 1'b0;
		end
		if (got < n) begin
			fetch_checker_inst.note_failure("timed out waiting for an instruction on idu_valid");
			idu_ready <= 1'b0;
		end
	endtask

	task automatic jump_to(input logic [31:0] addr);
		@(posedge clock);
		jump_wrong <= 1'b1;
		jump_addr <= addr;
		@(posedge clock);
		jump_wrong <= 1'b0;
	endtask

	initial begin
		int i;
		int gap;
		logic [31:0] addr;
		reset <= 1'b1;
		run <= 1'b0;
		host_req <= 1'b0;
		host_op <= bus_read_word;
		host_addr <= '0;
		host_wdata <= '0;
		jump_wrong <= 1'b0;
		jump_addr <= '0;
		idu_ready <= 1'b0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		for (i = 0; i < 64; i++) begin
			addr = ({$random(seed)} % mem_words) * 4;
			host_access(bus_write_word, addr, $random(seed));
			host_access(bus_read_word, addr, 32'd0);
		end
		fetch_checker_inst.end_test("host write and read");

		for (addr = 0; addr < 32'h800; addr += 4)
			host_access(bus_write_word, addr, fetch_checker_inst.image_word(addr));
		run <= 1'b1;
		accept_instructions(40, 0, span);
		fetch_checker_inst.end_test("cold straight-line fetch");

		jump_to(entry_addr);
		accept_instructions(40, 0, span);
		if (span > 3 * 39) // Hits deliver one word every 3 cycles.
			fetch_checker_inst.note_failure($sformatf(
				"refetch of 40 cached words took %0d cycles, so some missed", span));
		fetch_checker_inst.end_test("cached refetch");

		for (i = 0; i < 16; i++) begin
			jump_to(32'h100 + ({$random(seed)} % 192) * 4);
			accept_instructions(1 + {$random(seed)} % 4, 0, span);
			gap = {$random(seed)} % 16;
			idu_ready <= 1'b1; // Keep fetching so the next jump lands anywhere.
			repeat (gap) @(posedge clock);
		end
		idu_ready <= 1'b0;
		fetch_checker_inst.end_test("random redirects");

		jump_to(32'h600);
		accept_instructions(40, 30, span);
		fetch_checker_inst.end_test("decode back-pressure");

		$display("%0d checks, %0d errors", fetch_checker_inst.checks, fetch_checker_inst.errors);
		if (fetch_checker_inst.errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: tb.f
rtl/fetch_pkg.sv
rtl/bus_pkg.sv
rtl/icache.sv
rtl/main_memory.sv
rtl/bus_arbiter.sv
rtl/ifu.sv
rtl/fetch_top.sv
testbench/fetch_checker.sv
testbench/tb_fetch.sv
